// ==== common/eth_pkg.sv ====
//================================================
// Ethernet framing constants and GMII bus type
// CRC uses the reflected 802.3 polynomial, init all ones
// The residue applies to the raw register without inversion
//================================================

package eth_pkg;

    localparam logic [7:0] eth_preamble_byte = 8'h55;
    localparam logic [7:0] eth_sfd_byte = 8'hd5;
    localparam int eth_preamble_len = 7;

    // Register value left after a good frame and its FCS
    localparam logic [31:0] eth_crc_residue = 32'hdebb20e3;

    localparam logic [31:0] eth_crc_poly_rev = 32'hedb88320;

    // One GMII direction, dv_en is TX_EN or RX_DV
    typedef struct packed {
        logic [7:0] data;
        logic       dv_en;
        logic       er;
    } gmii_bus_t;

    // One byte of CRC-32, LSB first
    function automatic logic [31:0] crc32_step(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ eth_crc_poly_rev;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// ==== common/stream_pkg.sv ====
//================================================
// Byte stream beat and FIFO status pulse types
// user on the last beat marks the whole frame bad
//================================================

package stream_pkg;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } byte_beat_t;

    // Single-cycle pulses from a frame FIFO
    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } fifo_status_t;

endpackage

// ==== frame_fifo/frame_fifo.sv ====
//================================================
// Store-and-forward byte frame FIFO
// DEPTH must be a power of two
// Bad or oversize frames are dropped, input never stalls
// in_ready drops for one cycle while a frame is rewound
//================================================

`timescale 1ns/10ps

module frame_fifo #(
    parameter int DEPTH = 2048
) (
    input  logic                     logic_clk,
    input  logic                     logic_rst,
    input  stream_pkg::byte_beat_t   in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output stream_pkg::byte_beat_t   out_beat,
    output logic                     out_valid,
    input  logic                     out_ready,
    output stream_pkg::fifo_status_t status
);
    import stream_pkg::*;

    localparam int aw = $clog2(DEPTH);

    byte_beat_t mem [DEPTH];

    // Extra top bit tells full from empty
    logic [aw:0] wr_ptr;
    logic [aw:0] commit_ptr;
    logic [aw:0] rd_ptr;

    logic dropping;
    logic rewind;
    logic full;
    logic in_fire;
    logic wr_en;
    logic frame_end;
    logic frame_ok;
    logic load_out;

    assign full = (wr_ptr == {~rd_ptr[aw], rd_ptr[aw-1:0]});
    assign in_ready = !rewind;
    assign in_fire = in_valid && in_ready;
    assign wr_en = in_fire && !dropping && !full;
    assign frame_end = in_fire && in_beat.last;
    assign frame_ok = wr_en && in_beat.last && !in_beat.user;

    // Only committed bytes are visible to the read side
    assign load_out = (rd_ptr != commit_ptr) && (!out_valid || out_ready);

    // Write side and frame commit
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr <= '0;
            commit_ptr <= '0;
            dropping <= 1'b0;
            rewind <= 1'b0;
            status <= '0;
        end else begin
            if (rewind) begin
                wr_ptr <= commit_ptr;
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (frame_ok) begin
                commit_ptr <= wr_ptr + 1'b1;
            end

            // Buffer filled mid-frame, discard the remainder
            if (in_fire && !dropping && full) begin
                dropping <= !in_beat.last;
            end else if (frame_end) begin
                dropping <= 1'b0;
            end

            rewind <= frame_end && !frame_ok;

            status.overflow <= in_fire && !dropping && full;
            status.bad_frame <= wr_en && in_beat.last && in_beat.user;
            status.good_frame <= frame_ok;
        end
    end

    // Read pointer and output valid
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr <= '0;
            out_valid <= 1'b0;
        end else if (load_out) begin
            rd_ptr <= rd_ptr + 1'b1;
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Storage and output beat register
    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[aw-1:0]] <= in_beat;
        end
        if (load_out) begin
            out_beat <= mem[rd_ptr[aw-1:0]];
        end
    end

endmodule

// ==== mac/eth_mac_tx.sv ====
//================================================
// GMII transmit MAC, one byte per clock
// Input must not stall mid-frame, else er and underflow
// Gap is the larger of cfg_ifg and 12 cycles
//================================================

`timescale 1ns/10ps

module eth_mac_tx #(
    parameter int MIN_FRAME_LENGTH = 64,
    parameter bit ENABLE_PADDING = 1'b1
) (
    input  logic                   logic_clk,
    input  logic                   logic_rst,
    input  stream_pkg::byte_beat_t in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    output eth_pkg::gmii_bus_t     gmii_tx,
    input  logic [7:0]             cfg_ifg,
    input  logic                   cfg_tx_enable,
    output logic                   tx_underflow
);
    import eth_pkg::*;

    // Data bytes before the FCS
    localparam int unsigned min_data_len = MIN_FRAME_LENGTH - 4;
    localparam logic [7:0] min_ifg = 8'd12;

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_data,
        st_pad,
        st_fcs,
        st_gap
    } tx_state_t;

    tx_state_t   state;
    logic [15:0] cnt;
    logic [31:0] crc;
    logic [7:0]  gap_len;

    assign gap_len = (cfg_ifg > min_ifg) ? cfg_ifg : min_ifg;
    assign in_ready = (state == st_data);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state <= st_idle;
            cnt <= '0;
            gmii_tx <= '0;
            tx_underflow <= 1'b0;
        end else begin
            gmii_tx.dv_en <= 1'b0;
            gmii_tx.er <= 1'b0;
            tx_underflow <= 1'b0;
            case (state)
                st_idle: begin
                    if (in_valid && cfg_tx_enable) begin
                        gmii_tx.data <= eth_preamble_byte;
                        gmii_tx.dv_en <= 1'b1;
                        cnt <= 16'd1;
                        state <= st_preamble;
                    end
                end
                st_preamble: begin
                    gmii_tx.dv_en <= 1'b1;
                    if (cnt < eth_preamble_len) begin
                        gmii_tx.data <= eth_preamble_byte;
                        cnt <= cnt + 16'd1;
                    end else begin
                        gmii_tx.data <= eth_sfd_byte;
                        cnt <= '0;
                        state <= st_data;
                    end
                end
                st_data: begin
                    gmii_tx.dv_en <= 1'b1;
                    if (in_valid) begin
                        gmii_tx.data <= in_beat.data;
                        cnt <= cnt + 16'd1;
                        if (in_beat.last) begin
                            // Bad frame reaching the MAC goes out with er
                            gmii_tx.er <= in_beat.user;
                            if (ENABLE_PADDING && (32'(cnt) + 1 < min_data_len)) begin
                                state <= st_pad;
                            end else begin
                                cnt <= '0;
                                state <= st_fcs;
                            end
                        end
                    end else begin
                        // Source ran dry, abort the frame
                        gmii_tx.data <= 8'h00;
                        gmii_tx.er <= 1'b1;
                        tx_underflow <= 1'b1;
                        cnt <= '0;
                        state <= st_gap;
                    end
                end
                st_pad: begin
                    gmii_tx.dv_en <= 1'b1;
                    gmii_tx.data <= 8'h00;
                    cnt <= cnt + 16'd1;
                    if (32'(cnt) + 1 >= min_data_len) begin
                        cnt <= '0;
                        state <= st_fcs;
                    end
                end
                st_fcs: begin
                    // Inverted CRC, low byte first
                    gmii_tx.dv_en <= 1'b1;
                    gmii_tx.data <= ~crc[7:0];
                    cnt <= cnt + 16'd1;
                    if (cnt == 16'd3) begin
                        cnt <= '0;
                        state <= st_gap;
                    end
                end
                st_gap: begin
                    cnt <= cnt + 16'd1;
                    if (cnt + 16'd1 >= {8'd0, gap_len}) begin
                        cnt <= '0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // CRC over data and pad, then shifted out as FCS
    always_ff @(posedge logic_clk) begin
        if (state == st_preamble && cnt >= eth_preamble_len) begin
            crc <= '1;
        end else if (state == st_data && in_valid) begin
            crc <= crc32_step(crc, in_beat.data);
        end else if (state == st_pad) begin
            crc <= crc32_step(crc, 8'h00);
        end else if (state == st_fcs) begin
            crc <= {8'h00, crc[31:8]};
        end
    end

endmodule

// ==== mac/eth_mac_rx.sv ====
//================================================
// GMII receive MAC, one byte per clock, no back-pressure
// Output lags the wire by the four FCS bytes plus one
// A frame with no payload ends with a dummy bad beat
//================================================

`timescale 1ns/10ps

module eth_mac_rx (
    input  logic                   logic_clk,
    input  logic                   logic_rst,
    input  eth_pkg::gmii_bus_t     gmii_rx,
    input  logic                   cfg_rx_enable,
    output stream_pkg::byte_beat_t out_beat,
    output logic                   out_valid,
    output logic                   rx_bad_frame,
    output logic                   rx_bad_fcs
);
    import eth_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_preamble,
        st_payload,
        st_skip
    } rx_state_t;

    rx_state_t   state;
    logic [31:0] crc;
    logic [31:0] hold_line;
    logic [2:0]  hold_cnt;
    logic [7:0]  pend_data;
    logic        pend_valid;
    logic        er_seen;
    logic        fcs_bad;
    logic        frame_bad;

    assign fcs_bad = (crc != eth_crc_residue);

    // Too short to carry any payload beyond the FCS
    assign frame_bad = er_seen || !pend_valid || fcs_bad;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state <= st_idle;
            hold_cnt <= '0;
            pend_valid <= 1'b0;
            er_seen <= 1'b0;
            out_valid <= 1'b0;
            rx_bad_frame <= 1'b0;
            rx_bad_fcs <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            rx_bad_frame <= 1'b0;
            rx_bad_fcs <= 1'b0;
            case (state)
                st_idle: begin
                    if (cfg_rx_enable && gmii_rx.dv_en) begin
                        if (gmii_rx.data == eth_preamble_byte) begin
                            state <= st_preamble;
                        end else begin
                            state <= st_skip;
                        end
                    end
                end
                st_preamble: begin
                    if (!gmii_rx.dv_en) begin
                        state <= st_idle;
                    end else if (gmii_rx.data == eth_sfd_byte) begin
                        hold_cnt <= '0;
                        pend_valid <= 1'b0;
                        er_seen <= 1'b0;
                        state <= st_payload;
                    end else if (gmii_rx.data != eth_preamble_byte) begin
                        state <= st_skip;
                    end
                end
                st_payload: begin
                    if (gmii_rx.dv_en) begin
                        er_seen <= er_seen | gmii_rx.er;
                        if (hold_cnt == 3'd4) begin
                            pend_valid <= 1'b1;
                            out_valid <= pend_valid;
                        end else begin
                            hold_cnt <= hold_cnt + 3'd1;
                        end
                    end else begin
                        // End of frame, held bytes are the FCS
                        out_valid <= 1'b1;
                        rx_bad_frame <= frame_bad;
                        rx_bad_fcs <= fcs_bad;
                        state <= st_idle;
                    end
                end
                st_skip: begin
                    if (!gmii_rx.dv_en) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // CRC, four-byte delay line and output beat
    always_ff @(posedge logic_clk) begin
        if (state == st_preamble && gmii_rx.dv_en && gmii_rx.data == eth_sfd_byte) begin
            crc <= '1;
        end else if (state == st_payload && gmii_rx.dv_en) begin
            crc <= crc32_step(crc, gmii_rx.data);
            hold_line <= {hold_line[23:0], gmii_rx.data};
            if (hold_cnt == 3'd4) begin
                pend_data <= hold_line[31:24];
                out_beat.data <= pend_data;
                out_beat.last <= 1'b0;
                out_beat.user <= 1'b0;
            end
        end else if (state == st_payload) begin
            out_beat.data <= pend_data;
            out_beat.last <= 1'b1;
            out_beat.user <= frame_bad;
        end
    end

endmodule

// ==== hdl/eth_mac_fifo.sv ====
//================================================
// Gigabit Ethernet MAC with TX and RX frame FIFOs
// Single clock, GMII registers run on logic_clk
//================================================

`timescale 1ns/10ps

module eth_mac_fifo #(
    parameter int TX_FIFO_DEPTH = 2048,
    parameter int RX_FIFO_DEPTH = 2048,
    parameter int MIN_FRAME_LENGTH = 64,
    parameter bit ENABLE_PADDING = 1'b1
) (
    input  logic                     logic_clk,
    input  logic                     logic_rst,
    input  stream_pkg::byte_beat_t   tx_in_beat,
    input  logic                     tx_in_valid,
    output logic                     tx_in_ready,
    output stream_pkg::byte_beat_t   rx_out_beat,
    output logic                     rx_out_valid,
    input  logic                     rx_out_ready,
    input  eth_pkg::gmii_bus_t       gmii_rx,
    output eth_pkg::gmii_bus_t       gmii_tx,
    output stream_pkg::fifo_status_t tx_fifo_status,
    output stream_pkg::fifo_status_t rx_fifo_status,
    output logic                     tx_underflow,
    output logic                     rx_bad_frame,
    output logic                     rx_bad_fcs,
    input  logic [7:0]               cfg_ifg,
    input  logic                     cfg_tx_enable,
    input  logic                     cfg_rx_enable
);
    import stream_pkg::*;

    byte_beat_t tx_fifo_beat;
    logic       tx_fifo_valid;
    logic       tx_fifo_ready;
    byte_beat_t rx_mac_beat;
    logic       rx_mac_valid;

    frame_fifo #(
        .DEPTH (TX_FIFO_DEPTH)
    ) u_tx_fifo (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .in_beat   (tx_in_beat),
        .in_valid  (tx_in_valid),
        .in_ready  (tx_in_ready),
        .out_beat  (tx_fifo_beat),
        .out_valid (tx_fifo_valid),
        .out_ready (tx_fifo_ready),
        .status    (tx_fifo_status)
    );

    eth_mac_tx #(
        .MIN_FRAME_LENGTH (MIN_FRAME_LENGTH),
        .ENABLE_PADDING   (ENABLE_PADDING)
    ) u_mac_tx (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .in_beat       (tx_fifo_beat),
        .in_valid      (tx_fifo_valid),
        .in_ready      (tx_fifo_ready),
        .gmii_tx       (gmii_tx),
        .cfg_ifg       (cfg_ifg),
        .cfg_tx_enable (cfg_tx_enable),
        .tx_underflow  (tx_underflow)
    );

    eth_mac_rx u_mac_rx (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .gmii_rx       (gmii_rx),
        .cfg_rx_enable (cfg_rx_enable),
        .out_beat      (rx_mac_beat),
        .out_valid     (rx_mac_valid),
        .rx_bad_frame  (rx_bad_frame),
        .rx_bad_fcs    (rx_bad_fcs)
    );

    // GMII cannot stall, so the RX FIFO ready is left open
    frame_fifo #(
        .DEPTH (RX_FIFO_DEPTH)
    ) u_rx_fifo (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .in_beat   (rx_mac_beat),
        .in_valid  (rx_mac_valid),
        .in_ready  (),
        .out_beat  (rx_out_beat),
        .out_valid (rx_out_valid),
        .out_ready (rx_out_ready),
        .status    (rx_fifo_status)
    );

endmodule

// ==== verification/tb_eth_mac_fifo.sv ====
//==================================================
// Directed testbench for the Ethernet MAC with FIFOs
// GMII TX loops back to RX unless a test injects
// FIFO depths are 256, minimum frame is 64 bytes
//==================================================

`timescale 1ns/10ps

module tb_eth_mac_fifo;
    import eth_pkg::*;
    import stream_pkg::*;

    localparam int fifo_depth = 256;
    localparam int min_frame_len = 64;
    localparam int pad_target = min_frame_len - 4;
    localparam int clk_period = 10;
    // Longest frame crosses two FIFOs and both MACs
    localparam int frame_count = 20;
    localparam int frame_cycles = 4 * (300 + 60);

    logic         logic_clk;
    logic         logic_rst;
    byte_beat_t   tx_in_beat;
    logic         tx_in_valid;
    logic         tx_in_ready;
    byte_beat_t   rx_out_beat;
    logic         rx_out_valid;
    logic         rx_out_ready;
    gmii_bus_t    gmii_rx;
    gmii_bus_t    gmii_tx;
    gmii_bus_t    inj_bus;
    logic         inject_sel;
    fifo_status_t tx_fifo_status;
    fifo_status_t rx_fifo_status;
    logic         tx_underflow;
    logic         rx_bad_frame;
    logic         rx_bad_fcs;
    logic [7:0]   cfg_ifg;
    logic         cfg_tx_enable;
    logic         cfg_rx_enable;

    integer     seed;
    logic [7:0] pay_q[$];
    logic [7:0] exp_data_q[$];
    int         exp_len_q[$];
    byte_beat_t rx_beats[$];
    logic [7:0] tx_cap[$];
    int         gaps[$];
    bit         hold_rx;

    int rx_frames_done = 0;
    int frames_taken = 0;
    int tx_good_cnt = 0;
    int tx_bad_cnt = 0;
    int tx_ovf_cnt = 0;
    int rx_good_cnt = 0;
    int rx_bad_cnt = 0;
    int rx_ovf_cnt = 0;
    int rx_bad_frame_cnt = 0;
    int rx_bad_fcs_cnt = 0;
    int tx_underflow_cnt = 0;
    int idle_cycles = 0;
    bit prev_dv = 1'b0;
    bit frame_seen = 1'b0;

    // Loopback unless a test takes over the RX side
    assign gmii_rx = inject_sel ? inj_bus : gmii_tx;

    eth_mac_fifo #(
        .TX_FIFO_DEPTH    (fifo_depth),
        .RX_FIFO_DEPTH    (fifo_depth),
        .MIN_FRAME_LENGTH (min_frame_len),
        .ENABLE_PADDING   (1'b1)
    ) u_dut (
        .logic_clk      (logic_clk),
        .logic_rst      (logic_rst),
        .tx_in_beat     (tx_in_beat),
        .tx_in_valid    (tx_in_valid),
        .tx_in_ready    (tx_in_ready),
        .rx_out_beat    (rx_out_beat),
        .rx_out_valid   (rx_out_valid),
        .rx_out_ready   (rx_out_ready),
        .gmii_rx        (gmii_rx),
        .gmii_tx        (gmii_tx),
        .tx_fifo_status (tx_fifo_status),
        .rx_fifo_status (rx_fifo_status),
        .tx_underflow   (tx_underflow),
        .rx_bad_frame   (rx_bad_frame),
        .rx_bad_fcs     (rx_bad_fcs),
        .cfg_ifg        (cfg_ifg),
        .cfg_tx_enable  (cfg_tx_enable),
        .cfg_rx_enable  (cfg_rx_enable)
    );

    initial begin
        logic_clk = 1'b0;
        forever #(clk_period / 2) logic_clk = ~logic_clk;
    end

    // Sink, status counters, wire capture and gap measurement
    always @(negedge logic_clk) begin
        rx_out_ready = !hold_rx;
        if (rx_out_valid && rx_out_ready) begin
            rx_beats.push_back(rx_out_beat);
            if (rx_out_beat.last) begin
                rx_frames_done++;
            end
        end
        if (tx_fifo_status.good_frame) tx_good_cnt++;
        if (tx_fifo_status.bad_frame) tx_bad_cnt++;
        if (tx_fifo_status.overflow) tx_ovf_cnt++;
        if (rx_fifo_status.good_frame) rx_good_cnt++;
        if (rx_fifo_status.bad_frame) rx_bad_cnt++;
        if (rx_fifo_status.overflow) rx_ovf_cnt++;
        if (rx_bad_frame) rx_bad_frame_cnt++;
        if (rx_bad_fcs) rx_bad_fcs_cnt++;
        if (tx_underflow) tx_underflow_cnt++;
        if (gmii_tx.dv_en) begin
            tx_cap.push_back(gmii_tx.data);
            if (!prev_dv && frame_seen) begin
                gaps.push_back(idle_cycles);
            end
            idle_cycles = 0;
            frame_seen = 1'b1;
        end else begin
            idle_cycles++;
        end
        prev_dv = gmii_tx.dv_en;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopping at first failure");
    endtask

    // Bit-serial reflected CRC-32
    function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] r;
        logic        fb;
        r = crc;
        for (int i = 0; i < 8; i++) begin
            fb = r[0] ^ b[i];
            r = r >> 1;
            if (fb) begin
                r = r ^ 32'hedb88320;
            end
        end
        return r;
    endfunction

    task automatic make_payload(input int len);
        logic [31:0] rnd;
        pay_q.delete();
        repeat (len) begin
            rnd = $random(seed);
            pay_q.push_back(rnd[7:0]);
        end
    endtask

    // Queue the payload as expected output, zero padded to min_len
    task automatic expect_payload(input int min_len);
        int n;
        int total;
        n = pay_q.size();
        total = (n < min_len) ? min_len : n;
        for (int i = 0; i < total; i++) begin
            exp_data_q.push_back((i < n) ? pay_q[i] : 8'h00);
        end
        exp_len_q.push_back(total);
    endtask

    task automatic drive_frame(input bit bad);
        int n;
        n = pay_q.size();
        for (int i = 0; i < n; i++) begin
            tx_in_beat.data = pay_q[i];
            tx_in_beat.last = (i == n - 1);
            tx_in_beat.user = bad && (i == n - 1);
            tx_in_valid = 1'b1;
            while (!tx_in_ready) @(negedge logic_clk);
            @(negedge logic_clk);
        end
        tx_in_valid = 1'b0;
        tx_in_beat = '0;
    endtask

    // Handcrafted GMII frame on the RX side
    task automatic inject_gmii(input bit corrupt_fcs, input bit set_er);
        logic [7:0]  frame_bytes[$];
        logic [31:0] crc;
        int          n;
        n = pay_q.size();
        crc = 32'hffffffff;
        for (int i = 0; i < n; i++) begin
            crc = crc_update(crc, pay_q[i]);
        end
        crc = ~crc;
        repeat (7) frame_bytes.push_back(eth_preamble_byte);
        frame_bytes.push_back(eth_sfd_byte);
        for (int i = 0; i < n; i++) begin
            frame_bytes.push_back(pay_q[i]);
        end
        for (int i = 0; i < 4; i++) begin
            frame_bytes.push_back(crc[8*i +: 8]);
        end
        if (corrupt_fcs) begin
            frame_bytes[n + 9] = frame_bytes[n + 9] ^ 8'h5a;
        end
        inject_sel = 1'b1;
        @(negedge logic_clk);
        for (int i = 0; i < frame_bytes.size(); i++) begin
            inj_bus.data = frame_bytes[i];
            inj_bus.dv_en = 1'b1;
            inj_bus.er = set_er && (i == 12);
            @(negedge logic_clk);
        end
        inj_bus = '0;
        repeat (4) @(negedge logic_clk);
        inject_sel = 1'b0;
    endtask

    task automatic check_next_frame();
        int         len;
        byte_beat_t beat;
        logic [7:0] want;
        while (rx_frames_done <= frames_taken) @(negedge logic_clk);
        assert (exp_len_q.size() > 0)
            else fail_now($sformatf("Error at %0t ns: unexpected frame at rx_out", $time));
        len = exp_len_q.pop_front();
        for (int i = 0; i < len; i++) begin
            beat = rx_beats.pop_front();
            want = exp_data_q.pop_front();
            assert (beat.last == (i == len - 1))
                else fail_now($sformatf("Error at %0t ns: last at byte %0d of %0d",
                                        $time, i, len));
            assert (beat.data == want)
                else fail_now($sformatf("Error at %0t ns: byte %0d is %h, expected %h",
                                        $time, i, beat.data, want));
        end
        assert (beat.user == 1'b0)
            else fail_now($sformatf("Error at %0t ns: good frame marked bad", $time));
        frames_taken++;
    endtask

    task automatic check_reset_state();
        assert (tx_in_ready && !rx_out_valid && !gmii_tx.dv_en && !gmii_tx.er)
            else fail_now($sformatf("Error at %0t ns: handshake wrong after reset", $time));
        assert (tx_fifo_status == '0 && rx_fifo_status == '0 && !tx_underflow
                && !rx_bad_frame && !rx_bad_fcs)
            else fail_now($sformatf("Error at %0t ns: status pulse after reset", $time));
    endtask

    task automatic loopback_random();
        int len;
        int tx0;
        int rx0;
        tx0 = tx_good_cnt;
        rx0 = rx_good_cnt;
        repeat (5) begin
            len = 60 + ($unsigned($random(seed)) % 141);
            make_payload(len);
            expect_payload(pad_target);
            drive_frame(1'b0);
            check_next_frame();
        end
        assert (tx_good_cnt == tx0 + 5 && rx_good_cnt == rx0 + 5)
            else fail_now($sformatf("Error at %0t ns: good_frame counts %0d and %0d",
                                    $time, tx_good_cnt - tx0, rx_good_cnt - rx0));
    endtask

    task automatic short_frame_padding();
        logic [31:0] crc;
        logic [7:0]  want;
        make_payload(20);
        expect_payload(pad_target);
        tx_cap.delete();
        drive_frame(1'b0);
        check_next_frame();
        assert (tx_cap.size() == 8 + pad_target + 4)
            else fail_now($sformatf("Error at %0t ns: %0d bytes on gmii_tx", $time, tx_cap.size()));
        for (int i = 0; i < 7; i++) begin
            assert (tx_cap[i] == eth_preamble_byte)
                else fail_now($sformatf("Error at %0t ns: preamble byte %0d", $time, i));
        end
        assert (tx_cap[7] == eth_sfd_byte)
            else fail_now($sformatf("Error at %0t ns: delimiter is %h", $time, tx_cap[7]));
        crc = 32'hffffffff;
        for (int i = 0; i < pad_target; i++) begin
            want = (i < 20) ? pay_q[i] : 8'h00;
            assert (tx_cap[8 + i] == want)
                else fail_now($sformatf("Error at %0t ns: wire data byte %0d", $time, i));
            crc = crc_update(crc, want);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            assert (tx_cap[8 + pad_target + i] == crc[8*i +: 8])
                else fail_now($sformatf("Error at %0t ns: FCS byte %0d is %h, expected %h",
                                        $time, i, tx_cap[8 + pad_target + i], crc[8*i +: 8]));
        end
    endtask

    task automatic bad_user_frame();
        int bad0;
        bad0 = tx_bad_cnt;
        make_payload(80);
        drive_frame(1'b1);
        while (tx_bad_cnt == bad0) @(negedge logic_clk);
        // A leaked bad frame would show up here instead
        make_payload(70);
        expect_payload(pad_target);
        drive_frame(1'b0);
        check_next_frame();
        assert (tx_bad_cnt == bad0 + 1)
            else fail_now($sformatf("Error at %0t ns: TX bad_frame count off", $time));
    endtask

    task automatic rx_error_injection();
        int bad0;
        int fcs0;
        int frm1;
        int done0;
        bad0 = rx_bad_cnt;
        fcs0 = rx_bad_fcs_cnt;
        done0 = rx_frames_done;
        make_payload(50);
        inject_gmii(1'b1, 1'b0);
        while (rx_bad_cnt == bad0) @(negedge logic_clk);
        assert (rx_bad_fcs_cnt == fcs0 + 1)
            else fail_now($sformatf("Error at %0t ns: no rx_bad_fcs pulse", $time));
        frm1 = rx_bad_frame_cnt;
        inject_gmii(1'b0, 1'b1);
        while (rx_bad_cnt == bad0 + 1) @(negedge logic_clk);
        assert (rx_bad_frame_cnt == frm1 + 1 && rx_bad_fcs_cnt == fcs0 + 1)
            else fail_now($sformatf("Error at %0t ns: er frame pulses wrong", $time));
        assert (rx_frames_done == done0)
            else fail_now($sformatf("Error at %0t ns: bad frame reached rx_out", $time));
    endtask

    task automatic ifg_spacing(input logic [7:0] ifg, input int min_gap);
        cfg_ifg = ifg;
        cfg_tx_enable = 1'b0;
        repeat (2) begin
            make_payload(60);
            expect_payload(pad_target);
            drive_frame(1'b0);
        end
        gaps.delete();
        cfg_tx_enable = 1'b1;
        check_next_frame();
        check_next_frame();
        assert (gaps.size() == 2 && gaps[1] >= min_gap)
            else fail_now($sformatf("Error at %0t ns: gap below %0d cycles", $time, min_gap));
        cfg_ifg = 8'd12;
    endtask

    task automatic rx_overflow_backpressure();
        int good0;
        int ovf0;
        good0 = rx_good_cnt;
        ovf0 = rx_ovf_cnt;
        hold_rx = 1'b1;
        repeat (3) begin
            make_payload(60);
            expect_payload(pad_target);
            drive_frame(1'b0);
        end
        while (rx_good_cnt < good0 + 3) @(negedge logic_clk);
        // Longer than the whole RX buffer
        make_payload(fifo_depth + 44);
        inject_gmii(1'b0, 1'b0);
        while (rx_ovf_cnt == ovf0) @(negedge logic_clk);
        make_payload(60);
        expect_payload(pad_target);
        drive_frame(1'b0);
        while (rx_good_cnt < good0 + 4) @(negedge logic_clk);
        // First beat of the oldest frame waits at the output
        assert (rx_out_valid && rx_out_beat.data == exp_data_q[0] && !rx_out_beat.last)
            else fail_now($sformatf("Error at %0t ns: output beat not held while stalled",
                                    $time));
        hold_rx = 1'b0;
        repeat (4) check_next_frame();
        assert (rx_ovf_cnt == ovf0 + 1)
            else fail_now($sformatf("Error at %0t ns: RX overflow count off", $time));
    endtask

    initial begin
        #(frame_count * frame_cycles * clk_period + 10000);
        fail_now("Timeout: the tests did not finish in the expected time");
    end

    initial begin
        seed = 32'h9ec672d8;
        logic_rst = 1'b1;
        tx_in_beat = '0;
        tx_in_valid = 1'b0;
        rx_out_ready = 1'b1;
        hold_rx = 1'b0;
        inj_bus = '0;
        inject_sel = 1'b0;
        cfg_ifg = 8'd12;
        cfg_tx_enable = 1'b1;
        cfg_rx_enable = 1'b1;
        repeat (2) @(posedge logic_clk);
        @(negedge logic_clk);
        logic_rst = 1'b0;
        check_reset_state();
        loopback_random();
        short_frame_padding();
        bad_user_frame();
        rx_error_injection();
        ifg_spacing(8'd20, 20);
        ifg_spacing(8'd4, 12);
        rx_overflow_backpressure();
        repeat (50) @(negedge logic_clk);
        assert (rx_frames_done == frames_taken && exp_len_q.size() == 0)
            else fail_now($sformatf("Error at %0t ns: stray or missing frames", $time));
        assert (tx_underflow_cnt == 0 && tx_ovf_cnt == 0)
            else fail_now($sformatf("Error at %0t ns: TX underflow or overflow", $time));
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== files.f ====
common/eth_pkg.sv
common/stream_pkg.sv
frame_fifo/frame_fifo.sv
mac/eth_mac_tx.sv
mac/eth_mac_rx.sv
hdl/eth_mac_fifo.sv
verification/tb_eth_mac_fifo.sv

// ==== Bender.yml ====
package:
  name: eth_mac_fifo

sources:
  - common/eth_pkg.sv
  - common/stream_pkg.sv
  - frame_fifo/frame_fifo.sv
  - mac/eth_mac_tx.sv
  - mac/eth_mac_rx.sv
  - hdl/eth_mac_fifo.sv
  - target: test
    files:
      - verification/tb_eth_mac_fifo.sv
